//--- vlog.f
source/mem_pkg.sv
source/mem_ifs.sv
source/byte_ram.sv
source/mem_ctrl.sv
source/fetch_unit.sv
source/load_store_unit.sv
source/mem_top.sv
verif/tb_mem_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f vlog.f --top-module tb_mem_top -o sim_tb_mem_top
out=$(./obj_dir/sim_tb_mem_top)
echo "$out"
echo "$out" | grep -q "All tests passed"

//--- verif/tb_mem_top.sv
`timescale 1ns/1ps

module tb_mem_top;

    localparam int timeout_cycles = 4000;

    logic clock = 1'b0;
    logic reset = 1'b1;
    logic fetch_enable_i = 1'b0;
    logic redirect_i = 1'b0;
    mem_pkg::addr_t redirect_pc_i = '0;
    logic instr_take_i = 1'b0;
    logic instr_valid_o;
    mem_pkg::word_t instr_o;
    mem_pkg::addr_t instr_pc_o;
    logic req_i = 1'b0;
    logic write_i = 1'b0;
    logic signed_i = 1'b0;
    mem_pkg::addr_t addr_i = '0;
    mem_pkg::word_t wdata_i = '0;
    mem_pkg::access_len_e length_i = mem_pkg::len_word;
    logic busy_o;
    logic done_o;
    mem_pkg::word_t rdata_o;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    mem_pkg::byte_t model [mem_pkg::addr_t];

    mem_top DUT (.*);

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input mem_pkg::word_t got,
                              input mem_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input mem_pkg::addr_t got,
                              input mem_pkg::addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    function automatic mem_pkg::addr_t rand_addr(input mem_pkg::addr_t mask);
        return mem_pkg::addr_t'($urandom()) & mask;
    endfunction

    // Little endian; extension from the top loaded bit.
    function automatic mem_pkg::word_t model_load(input mem_pkg::addr_t a,
                                                  input mem_pkg::access_len_e len,
                                                  input logic sgn);
        mem_pkg::word_t v;
        int n;
        v = '0;
        n = int'(len);
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = model[a + mem_pkg::addr_t'(i)];
        end
        if (sgn && n < 4 && v[8*n-1]) begin
            for (int i = 8 * n; i < 32; i++) begin
                v[i] = 1'b1;
            end
        end
        return v;
    endfunction

    task automatic do_access(input logic wr, input logic sgn, input mem_pkg::addr_t addr,
                             input mem_pkg::word_t wdata, input mem_pkg::access_len_e len,
                             input logic timed);
        int cycles;
        int n;
        n = int'(len);
        @(negedge clock);
        while (busy_o) @(negedge clock);
        @(posedge clock);
        req_i <= 1'b1;
        write_i <= wr;
        signed_i <= sgn;
        addr_i <= addr;
        wdata_i <= wdata;
        length_i <= len;
        // The unit samples the request at this edge.
        @(posedge clock);
        req_i <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            @(negedge clock);
        end while (!done_o);
        if (timed && cycles != (wr ? n + 2 : n + 3)) begin
            errors++;
            $display("done_o came %0d cycles after the request was sampled, expected %0d",
                     cycles, wr ? n + 2 : n + 3);
        end
        if (wr) begin
            for (int i = 0; i < n; i++) begin
                model[addr + mem_pkg::addr_t'(i)] = wdata[8*i +: 8];
            end
        end else begin
            check_word("rdata_o", rdata_o, model_load(addr, len, sgn));
        end
    endtask

    task automatic take_instr(input mem_pkg::addr_t exp_pc);
        @(negedge clock);
        while (!instr_valid_o) @(negedge clock);
        check_addr("instr_pc_o", instr_pc_o, exp_pc);
        check_word("instr_o", instr_o, model_load(exp_pc, mem_pkg::len_word, 1'b0));
        @(posedge clock);
        instr_take_i <= 1'b1;
        @(posedge clock);
        instr_take_i <= 1'b0;
    endtask

    task automatic report(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("Test %s: FAIL", name);
        end else begin
            $display("Test %s: ok", name);
        end
    endtask

    task automatic test_idle();
        int e;
        e = errors;
        for (int i = 0; i < 10; i++) begin
            @(negedge clock);
            check_flag("busy_o", busy_o, 1'b0);
            check_flag("done_o", done_o, 1'b0);
            check_flag("instr_valid_o", instr_valid_o, 1'b0);
        end
        report("idle after reset", e);
    endtask

    task automatic test_store_load();
        mem_pkg::addr_t base;
        int e;
        e = errors;
        for (int i = 0; i < 6; i++) begin
            base = rand_addr(17'h1fffc);
            do_access(1'b1, 1'b0, base, $urandom(), mem_pkg::len_word, 1'b1);
            do_access(1'b1, 1'b0, base + 17'(2 * ($urandom() % 2)), $urandom(),
                      mem_pkg::len_half, 1'b1);
            do_access(1'b1, 1'b0, base + 17'($urandom() % 4), $urandom(),
                      mem_pkg::len_byte, 1'b1);
            do_access(1'b0, 1'b0, base, '0, mem_pkg::len_word, 1'b1);
        end
        report("store and word load", e);
    endtask

    task automatic test_extension();
        mem_pkg::addr_t base;
        int e;
        e = errors;
        base = rand_addr(17'h1fffc);
        // Bytes 0 and 1 negative, byte 2 positive.
        do_access(1'b1, 1'b0, base, ($urandom() | 32'h0000_8080) & 32'hff7f_ffff,
                  mem_pkg::len_word, 1'b1);
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 4; k++) begin
                do_access(1'b0, s[0], base + 17'(k), '0, mem_pkg::len_byte, 1'b1);
            end
            do_access(1'b0, s[0], base, '0, mem_pkg::len_half, 1'b1);
            do_access(1'b0, s[0], base + 17'd2, '0, mem_pkg::len_half, 1'b1);
        end
        report("sign and zero extension", e);
    endtask

    task automatic test_fetch_order();
        int e;
        e = errors;
        for (int i = 0; i < 5; i++) begin
            do_access(1'b1, 1'b0, 17'(4 * i), $urandom(), mem_pkg::len_word, 1'b1);
        end
        @(posedge clock);
        fetch_enable_i <= 1'b1;
        for (int i = 0; i < 4; i++) begin
            take_instr(17'(4 * i));
        end
        report("fetch in order", e);
    endtask

    task automatic test_redirect();
        mem_pkg::addr_t target;
        int e;
        e = errors;
        target = rand_addr(17'h1fffc) | 17'h100;
        do_access(1'b1, 1'b0, target, $urandom(), mem_pkg::len_word, 1'b0);
        take_instr(17'd16);
        // Next fetch issues, then is granted; redirect lands mid transfer.
        @(posedge clock);
        @(posedge clock);
        redirect_i <= 1'b1;
        redirect_pc_i <= target;
        @(posedge clock);
        redirect_i <= 1'b0;
        take_instr(target);
        report("redirect during fetch", e);
    endtask

    task automatic test_concurrent();
        mem_pkg::addr_t base;
        mem_pkg::addr_t daddr;
        int e;
        e = errors;
        base = rand_addr(17'h1fff0);
        daddr = rand_addr(17'h1fffc);
        for (int i = 0; i < 4; i++) begin
            do_access(1'b1, 1'b0, base + 17'(4 * i), $urandom(), mem_pkg::len_word, 1'b0);
        end
        do_access(1'b1, 1'b0, daddr, $urandom(), mem_pkg::len_word, 1'b0);
        fork
            begin
                @(posedge clock);
                redirect_i <= 1'b1;
                redirect_pc_i <= base;
                @(posedge clock);
                redirect_i <= 1'b0;
                for (int i = 0; i < 4; i++) begin
                    take_instr(base + 17'(4 * i));
                end
            end
            begin
                // Load and refetch reach the controller on the same edge.
                do_access(1'b0, 1'b0, daddr, '0, mem_pkg::len_word, 1'b1);
                // Arrives while a fetch holds the RAM.
                do_access(1'b0, 1'b0, daddr, '0, mem_pkg::len_word, 1'b0);
            end
        join
        report("load during fetch", e);
    endtask

    initial begin
        void'($urandom(57844));
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        test_idle();
        test_store_load();
        test_extension();
        test_fetch_order();
        test_redirect();
        test_concurrent();
        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- source/mem_top.sv
`timescale 1ns/1ps

module mem_top (
    input logic clock,
    input logic reset,

    input logic fetch_enable_i,
    input logic redirect_i,
    input mem_pkg::addr_t redirect_pc_i,
    input logic instr_take_i,
    output logic instr_valid_o,
    output mem_pkg::word_t instr_o,
    output mem_pkg::addr_t instr_pc_o,

    input logic req_i,
    input logic write_i,
    input logic signed_i,
    input mem_pkg::addr_t addr_i,
    input mem_pkg::word_t wdata_i,
    input mem_pkg::access_len_e length_i,
    output logic busy_o,
    output logic done_o,
    output mem_pkg::word_t rdata_o
);

    fetch_port_if fetch_port ();
    data_port_if data_port ();
    ram_bus_if ram_bus ();

    fetch_unit u_fetch (
        .clock(clock),
        .reset(reset),
        .fetch_enable_i(fetch_enable_i),
        .redirect_i(redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .instr_take_i(instr_take_i),
        .instr_valid_o(instr_valid_o),
        .instr_o(instr_o),
        .instr_pc_o(instr_pc_o),
        .fetch(fetch_port)
    );

    load_store_unit u_lsu (
        .clock(clock),
        .reset(reset),
        .req_i(req_i),
        .write_i(write_i),
        .signed_i(signed_i),
        .addr_i(addr_i),
        .wdata_i(wdata_i),
        .length_i(length_i),
        .busy_o(busy_o),
        .done_o(done_o),
        .rdata_o(rdata_o),
        .data(data_port)
    );

    mem_ctrl u_ctrl (
        .clock(clock),
        .reset(reset),
        .fetch(fetch_port),
        .data(data_port),
        .ram(ram_bus)
    );

    byte_ram u_ram (
        .clock(clock),
        .ram(ram_bus)
    );

endmodule

//--- source/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
    input logic clock,
    input logic reset,
    input logic req_i,
    input logic write_i,
    input logic signed_i,
    input mem_pkg::addr_t addr_i,
    input mem_pkg::word_t wdata_i,
    input mem_pkg::access_len_e length_i,
    output logic busy_o,
    output logic done_o,
    output mem_pkg::word_t rdata_o,
    data_port_if.requester data
);

    logic active_q;
    logic done_q;

    logic write_q;
    logic signed_q;
    mem_pkg::addr_t addr_q;
    mem_pkg::word_t wdata_q;
    mem_pkg::access_len_e length_q;
    mem_pkg::word_t rdata_q;

    logic accept;
    logic finish;

    // New requests only while idle.
    assign accept = !active_q && req_i;
    assign finish = active_q && data.ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            active_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= finish;
            if (accept) begin
                active_q <= 1'b1;
            end else if (finish) begin
                active_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            write_q <= write_i;
            signed_q <= signed_i;
            addr_q <= addr_i;
            wdata_q <= wdata_i;
            length_q <= length_i;
        end
        if (finish && !write_q) begin
            rdata_q <= data.rdata;
        end
    end

    assign data.read = active_q && !write_q;
    assign data.write = active_q && write_q;
    assign data.addr = addr_q;
    assign data.wdata = wdata_q;
    assign data.length = length_q;
    assign data.is_signed = signed_q;

    assign busy_o = active_q;
    assign done_o = done_q;
    assign rdata_o = rdata_q;

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input logic clock,
    input logic reset,
    input logic fetch_enable_i,
    input logic redirect_i,
    input mem_pkg::addr_t redirect_pc_i,
    input logic instr_take_i,
    output logic instr_valid_o,
    output mem_pkg::word_t instr_o,
    output mem_pkg::addr_t instr_pc_o,
    fetch_port_if.requester fetch
);

    mem_pkg::addr_t pc_q;
    logic pending_q;
    logic discard_q;
    logic valid_q;

    mem_pkg::addr_t req_addr_q;
    mem_pkg::word_t instr_q;
    mem_pkg::addr_t instr_pc_q;

    logic issue;
    logic complete;
    logic keep;

    // Hold off while a data transfer owns the RAM.
    assign issue = fetch_enable_i && !valid_q && !pending_q && !redirect_i && !fetch.busy;
    assign complete = pending_q && fetch.ready;
    assign keep = complete && !discard_q && !redirect_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= mem_pkg::reset_pc;
            pending_q <= 1'b0;
            discard_q <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            if (issue) begin
                pending_q <= 1'b1;
            end else if (complete) begin
                pending_q <= 1'b0;
            end
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
                valid_q <= 1'b0;
                // The old fetch still runs to completion.
                discard_q <= pending_q && !fetch.ready;
            end else if (complete) begin
                discard_q <= 1'b0;
                if (!discard_q) begin
                    valid_q <= 1'b1;
                    pc_q <= req_addr_q + mem_pkg::addr_t'(mem_pkg::word_bytes);
                end
            end else if (instr_take_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            req_addr_q <= pc_q;
        end
        if (keep) begin
            instr_q <= fetch.data;
            instr_pc_q <= req_addr_q;
        end
    end

    assign fetch.read = pending_q;
    assign fetch.addr = req_addr_q;

    assign instr_valid_o = valid_q;
    assign instr_o = instr_q;
    assign instr_pc_o = instr_pc_q;

endmodule

//--- source/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl (
    input logic clock,
    input logic reset,
    fetch_port_if.controller fetch,
    data_port_if.controller data,
    ram_bus_if.controller ram
);

    logic xfer_q;
    logic owner_data_q;
    logic [2:0] cnt_q;
    logic fetch_ready_q;
    logic data_ready_q;

    logic write_q;
    logic signed_q;
    mem_pkg::access_len_e len_q;
    mem_pkg::addr_t base_q;
    mem_pkg::mem_word_u wdata_q;
    mem_pkg::mem_word_u asm_q;
    mem_pkg::mem_word_u asm_next;
    mem_pkg::word_t result_q;

    logic can_grant;
    logic grant_data;
    logic grant_fetch;
    logic last_cycle;
    logic [1:0] rd_idx;

    function automatic mem_pkg::word_t extend(
        input mem_pkg::word_t raw,
        input mem_pkg::access_len_e len,
        input logic sgn
    );
        case (len)
            mem_pkg::len_byte: return {{24{sgn & raw[7]}}, raw[7:0]};
            mem_pkg::len_half: return {{16{sgn & raw[15]}}, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    // No grant while a ready pulse is out, so the requester can drop.
    assign can_grant = !xfer_q && !fetch_ready_q && !data_ready_q;
    assign grant_data = can_grant && (data.read || data.write);
    assign grant_fetch = can_grant && !(data.read || data.write) && fetch.read;

    // Reads need one extra cycle for the registered RAM output.
    assign last_cycle = write_q ? (cnt_q == (3'(len_q) - 3'd1)) : (cnt_q == 3'(len_q));

    // Byte returned now belongs to the previous address.
    assign rd_idx = cnt_q[1:0] - 2'd1;

    always_comb begin
        asm_next = asm_q;
        asm_next.bytes[rd_idx] = ram.rdata;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            xfer_q <= 1'b0;
            owner_data_q <= 1'b0;
            cnt_q <= 3'd0;
            fetch_ready_q <= 1'b0;
            data_ready_q <= 1'b0;
        end else begin
            fetch_ready_q <= 1'b0;
            data_ready_q <= 1'b0;
            if (grant_data || grant_fetch) begin
                xfer_q <= 1'b1;
                owner_data_q <= grant_data;
                cnt_q <= 3'd0;
            end else if (xfer_q) begin
                if (last_cycle) begin
                    xfer_q <= 1'b0;
                    fetch_ready_q <= !owner_data_q;
                    data_ready_q <= owner_data_q;
                end else begin
                    cnt_q <= cnt_q + 3'd1;
                end
            end
        end
    end

    // Request fields are frozen for the whole transfer.
    always_ff @(posedge clock) begin
        if (grant_data) begin
            write_q <= data.write;
            len_q <= data.length;
            signed_q <= data.is_signed;
            base_q <= data.addr;
            wdata_q.word <= data.wdata;
        end else if (grant_fetch) begin
            write_q <= 1'b0;
            len_q <= mem_pkg::len_word;
            signed_q <= 1'b0;
            base_q <= fetch.addr;
        end
        if (xfer_q && !write_q && cnt_q != 3'd0) begin
            asm_q <= asm_next;
        end
        if (xfer_q && !write_q && last_cycle) begin
            result_q <= extend(asm_next.word, len_q, signed_q);
        end
    end

    assign fetch.busy = xfer_q && owner_data_q;
    assign data.busy = xfer_q && !owner_data_q;
    assign fetch.ready = fetch_ready_q;
    assign data.ready = data_ready_q;
    assign fetch.data = result_q;
    assign data.rdata = result_q;

    assign ram.rw = xfer_q && write_q;
    assign ram.addr = base_q + mem_pkg::addr_t'(cnt_q);
    assign ram.wdata = wdata_q.bytes[cnt_q[1:0]];

endmodule

//--- source/byte_ram.sv
`timescale 1ns/1ps

module byte_ram (
    input logic clock,
    ram_bus_if.memory ram
);

    mem_pkg::byte_t mem [mem_pkg::ram_depth];

    // Write lands at the edge.
    always_ff @(posedge clock) begin
        if (ram.rw) begin
            mem[ram.addr] <= ram.wdata;
        end
    end

    // Read byte valid one cycle after the address.
    always_ff @(posedge clock) begin
        ram.rdata <= mem[ram.addr];
    end

endmodule

//--- source/mem_ifs.sv
`timescale 1ns/1ps

// Instruction fetch request port.
interface fetch_port_if;
    logic read;
    mem_pkg::addr_t addr;
    logic busy;
    logic ready;
    mem_pkg::word_t data;

    modport requester (
        output read,
        output addr,
        input busy,
        input ready,
        input data
    );

    modport controller (
        input read,
        input addr,
        output busy,
        output ready,
        output data
    );
endinterface

// Load/store request port.
interface data_port_if;
    logic read;
    logic write;
    mem_pkg::addr_t addr;
    mem_pkg::word_t wdata;
    mem_pkg::access_len_e length;
    logic is_signed;
    logic busy;
    logic ready;
    mem_pkg::word_t rdata;

    modport requester (
        output read,
        output write,
        output addr,
        output wdata,
        output length,
        output is_signed,
        input busy,
        input ready,
        input rdata
    );

    modport controller (
        input read,
        input write,
        input addr,
        input wdata,
        input length,
        input is_signed,
        output busy,
        output ready,
        output rdata
    );
endinterface

// Single byte RAM cycle.
interface ram_bus_if;
    logic rw;
    mem_pkg::addr_t addr;
    mem_pkg::byte_t wdata;
    mem_pkg::byte_t rdata;

    modport controller (
        output rw,
        output addr,
        output wdata,
        input rdata
    );

    modport memory (
        input rw,
        input addr,
        input wdata,
        output rdata
    );
endinterface

//--- source/mem_pkg.sv
package mem_pkg;

    // RAM geometry.
    localparam int addr_width = 17;
    localparam int ram_depth = 2 ** addr_width;

    // Bytes per instruction word.
    localparam int word_bytes = 4;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [7:0] byte_t;
    typedef logic [31:0] word_t;

    // Value is the number of RAM byte cycles.
    typedef enum logic [2:0] {
        len_byte = 3'd1,
        len_half = 3'd2,
        len_word = 3'd4
    } access_len_e;

    // Byte 0 is the least significant byte.
    typedef union packed {
        word_t word;
        byte_t [3:0] bytes;
    } mem_word_u;

    // Fetch start address.
    localparam addr_t reset_pc = '0;

endpackage
